//--- hw/armPipe_params.svh
`ifndef ARMPIPE_PARAMS_SVH
`define ARMPIPE_PARAMS_SVH

`define ARMPIPE_DATA_WIDTH 32
`define ARMPIPE_REG_COUNT 16
`define ARMPIPE_REG_ADDR_WIDTH 4
`define ARMPIPE_PC_REG 15 // Reads as pc+8, never written

`endif

//--- hw/armPipePkg.sv
`default_nettype none
`include "armPipe_params.svh"

package armPipePkg;

	typedef enum logic [3:0] {
		aluAnd,
		aluEor,
		aluSub,
		aluRsb,
		aluAdd,
		aluOrr,
		aluMov,
		aluBic,
		aluCmp,
		aluNop
	} aluOpT;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	typedef struct packed {
		aluOpT aluOp;
		logic aluSrcImm; // Operand 2 from the immediate
		logic setFlags;
		logic regWrite;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		logic [3:0] cond;
		logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] rn;
		logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] rm;
		logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] rd;
		logic [`ARMPIPE_DATA_WIDTH-1:0] rnData;
		logic [`ARMPIPE_DATA_WIDTH-1:0] rmData;
		logic [`ARMPIPE_DATA_WIDTH-1:0] imm;
	} decExT;

	typedef struct packed {
		logic regWrite;
		logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] rd;
		logic [`ARMPIPE_DATA_WIDTH-1:0] result;
		flagsT flags; // Flags after this instruction
	} exWbT;

	typedef struct packed {
		logic regWrite;
		logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] rd;
		logic [`ARMPIPE_DATA_WIDTH-1:0] result;
	} retireT;

endpackage

`default_nettype wire

//--- hw/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
	input  logic [1:0] instrClass,
	input  logic [3:0] funct,
	input  logic immBit,
	input  logic sBit,
	output armPipePkg::ctrlT ctrl
);

	always_comb begin
		ctrl.aluOp = armPipePkg::aluNop;
		ctrl.aluSrcImm = immBit;
		ctrl.setFlags = 1'b0;
		ctrl.regWrite = 1'b0;
		if (instrClass == 2'b00) begin // Data processing only
			ctrl.setFlags = sBit;
			ctrl.regWrite = 1'b1;
			case (funct)
				4'b0000: ctrl.aluOp = armPipePkg::aluAnd;
				4'b0001: ctrl.aluOp = armPipePkg::aluEor;
				4'b0010: ctrl.aluOp = armPipePkg::aluSub;
				4'b0011: ctrl.aluOp = armPipePkg::aluRsb;
				4'b0100: ctrl.aluOp = armPipePkg::aluAdd;
				4'b1100: ctrl.aluOp = armPipePkg::aluOrr;
				4'b1101: ctrl.aluOp = armPipePkg::aluMov;
				4'b1110: ctrl.aluOp = armPipePkg::aluBic;
				4'b1010: begin
					ctrl.aluOp = armPipePkg::aluCmp;
					ctrl.setFlags = 1'b1; // Compare only updates flags
					ctrl.regWrite = 1'b0;
				end
				default: begin
					ctrl.setFlags = 1'b0;
					ctrl.regWrite = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`timescale 1ns/1ns
`default_nettype none
`include "armPipe_params.svh"

module registerFile (
	input  logic Clk,
	input  logic rstN,
	input  logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] raddr1,
	input  logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] raddr2,
	input  logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] waddr,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] wdata,
	input  logic writeEn,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] pcPlus8,
	output logic [`ARMPIPE_DATA_WIDTH-1:0] rdata1,
	output logic [`ARMPIPE_DATA_WIDTH-1:0] rdata2
);

	logic [`ARMPIPE_DATA_WIDTH-1:0] regs [0:`ARMPIPE_REG_COUNT-2]; // r0 to r14

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `ARMPIPE_REG_COUNT - 1; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && waddr != `ARMPIPE_PC_REG) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == `ARMPIPE_PC_REG) ? pcPlus8 :
		(writeEn && raddr1 == waddr) ? wdata : regs[raddr1]; // Write-through
	assign rdata2 = (raddr2 == `ARMPIPE_PC_REG) ? pcPlus8 :
		(writeEn && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "armPipe_params.svh"

module decodeStage (
	input  logic Clk,
	input  logic rstN,
	input  logic instrValid,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] instr,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] pc,
	input  logic wbWriteEn,
	input  logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] wbRd,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] wbData,
	output logic decValid,
	output armPipePkg::decExT decOut
);

	logic [3:0] cond;
	logic [1:0] instrClass;
	logic immBit;
	logic [3:0] funct;
	logic sBit;
	logic [`ARMPIPE_REG_ADDR_WIDTH-1:0] rn, rd, rm;
	logic [7:0] imm8;
	logic [`ARMPIPE_DATA_WIDTH-1:0] pcPlus8, rnData, rmData;
	armPipePkg::ctrlT unitCtrl;

	assign cond = instr[31:28];
	assign instrClass = instr[27:26];
	assign immBit = instr[25];
	assign funct = instr[24:21];
	assign sBit = instr[20];
	assign rn = instr[19:16];
	assign rd = instr[15:12];
	assign rm = instr[3:0];
	assign imm8 = instr[7:0]; // No rotation
	assign pcPlus8 = pc + `ARMPIPE_DATA_WIDTH'(8);

	controlUnit ctrlUnit (
		.instrClass(instrClass),
		.funct(funct),
		.immBit(immBit),
		.sBit(sBit),
		.ctrl(unitCtrl)
	);

	registerFile regFile (
		.Clk(Clk),
		.rstN(rstN),
		.raddr1(rn),
		.raddr2(rm),
		.waddr(wbRd),
		.wdata(wbData),
		.writeEn(wbWriteEn),
		.pcPlus8(pcPlus8),
		.rdata1(rnData),
		.rdata2(rmData)
	);

	assign decValid = instrValid;

	always_comb begin
		decOut.ctrl = unitCtrl;
		if (!instrValid) begin // Bubble carries no side effects
			decOut.ctrl.aluOp = armPipePkg::aluNop;
			decOut.ctrl.setFlags = 1'b0;
			decOut.ctrl.regWrite = 1'b0;
		end
		decOut.cond = cond;
		decOut.rn = rn;
		decOut.rm = rm;
		decOut.rd = rd;
		decOut.rnData = rnData;
		decOut.rmData = rmData;
		decOut.imm = {{(`ARMPIPE_DATA_WIDTH - 8){1'b0}}, imm8};
	end

endmodule

`default_nettype wire

//--- hw/pipeReg.sv
`timescale 1ns/1ns
`default_nettype none

module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic Clk,
	input  logic rstN,
	input  logic inValid,
	input  payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge Clk) begin
		outData <= inData; // Qualified by outValid downstream
	end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "armPipe_params.svh"

module executeStage (
	input  logic Clk,
	input  logic rstN,
	input  logic exValid,
	input  armPipePkg::decExT exIn,
	input  logic wbValid,
	input  armPipePkg::exWbT wbIn,
	output logic exWbValid,
	output armPipePkg::exWbT exWbOut,
	output armPipePkg::flagsT flags
);

	localparam int W = `ARMPIPE_DATA_WIDTH;
	localparam int W1 = W + 1;

	logic fwdRn, fwdRm, condPass, carry, overflow, flagsEn;
	logic [W-1:0] opA, rmVal, opB, result;
	armPipePkg::flagsT nextFlags;

	assign fwdRn = wbValid && wbIn.regWrite && wbIn.rd == exIn.rn && exIn.rn != `ARMPIPE_PC_REG;
	assign fwdRm = wbValid && wbIn.regWrite && wbIn.rd == exIn.rm && exIn.rm != `ARMPIPE_PC_REG;
	assign opA = fwdRn ? wbIn.result : exIn.rnData;
	assign rmVal = fwdRm ? wbIn.result : exIn.rmData;
	assign opB = exIn.ctrl.aluSrcImm ? exIn.imm : rmVal;

	always_comb begin
		case (exIn.cond)
			4'h0: condPass = flags.z;
			4'h1: condPass = !flags.z;
			4'h2: condPass = flags.c;
			4'h3: condPass = !flags.c;
			4'h4: condPass = flags.n;
			4'h5: condPass = !flags.n;
			4'h6: condPass = flags.v;
			4'h7: condPass = !flags.v;
			4'h8: condPass = flags.c && !flags.z;
			4'h9: condPass = !flags.c || flags.z;
			4'ha: condPass = flags.n == flags.v;
			4'hb: condPass = flags.n != flags.v;
			4'hc: condPass = !flags.z && flags.n == flags.v;
			4'hd: condPass = flags.z || flags.n != flags.v;
			4'he: condPass = 1'b1;
			default: condPass = 1'b0; // NV never executes
		endcase
	end

	always_comb begin
		result = '0;
		carry = flags.c; // Logical ops keep c and v
		overflow = flags.v;
		case (exIn.ctrl.aluOp)
			armPipePkg::aluAnd: result = opA & opB;
			armPipePkg::aluEor: result = opA ^ opB;
			armPipePkg::aluOrr: result = opA | opB;
			armPipePkg::aluMov: result = opB;
			armPipePkg::aluBic: result = opA & ~opB;
			armPipePkg::aluAdd: begin
				{carry, result} = {1'b0, opA} + {1'b0, opB};
				overflow = (opA[W-1] == opB[W-1]) && (result[W-1] != opA[W-1]);
			end
			armPipePkg::aluSub, armPipePkg::aluCmp: begin
				{carry, result} = {1'b0, opA} + {1'b0, ~opB} + W1'(1); // Carry is not-borrow
				overflow = (opA[W-1] != opB[W-1]) && (result[W-1] != opA[W-1]);
			end
			armPipePkg::aluRsb: begin
				{carry, result} = {1'b0, opB} + {1'b0, ~opA} + W1'(1);
				overflow = (opB[W-1] != opA[W-1]) && (result[W-1] != opB[W-1]);
			end
			default: result = '0;
		endcase
	end

	assign nextFlags.n = result[W-1];
	assign nextFlags.z = (result == '0);
	assign nextFlags.c = carry;
	assign nextFlags.v = overflow;
	assign flagsEn = exValid && condPass && exIn.ctrl.setFlags;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (flagsEn) begin
			flags <= nextFlags;
		end
	end

	assign exWbValid = exValid;
	assign exWbOut.regWrite = exValid && condPass && exIn.ctrl.regWrite;
	assign exWbOut.rd = exIn.rd;
	assign exWbOut.result = result;
	assign exWbOut.flags = flagsEn ? nextFlags : flags;

endmodule

`default_nettype wire

//--- hw/armPipe.sv
`timescale 1ns/1ns
`default_nettype none
`include "armPipe_params.svh"

module armPipe (
	input  logic Clk,
	input  logic rstN,
	input  logic instrValid,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] instr,
	input  logic [`ARMPIPE_DATA_WIDTH-1:0] pc,
	output logic retireValid,
	output armPipePkg::retireT retire,
	output armPipePkg::flagsT flags
);

	logic decValid, exValid, exWbValid, wbValid, wbWriteEn;
	armPipePkg::decExT decOut, exIn;
	armPipePkg::exWbT exWbOut, wbOut;

	decodeStage decode (
		.Clk(Clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.wbWriteEn(wbWriteEn),
		.wbRd(wbOut.rd),
		.wbData(wbOut.result),
		.decValid(decValid),
		.decOut(decOut)
	);

	pipeReg #(.payloadT(armPipePkg::decExT)) decExReg (
		.Clk(Clk),
		.rstN(rstN),
		.inValid(decValid),
		.inData(decOut),
		.outValid(exValid),
		.outData(exIn)
	);

	executeStage execute (
		.Clk(Clk),
		.rstN(rstN),
		.exValid(exValid),
		.exIn(exIn),
		.wbValid(wbValid),
		.wbIn(wbOut),
		.exWbValid(exWbValid),
		.exWbOut(exWbOut),
		.flags(flags)
	);

	pipeReg #(.payloadT(armPipePkg::exWbT)) exWbReg (
		.Clk(Clk),
		.rstN(rstN),
		.inValid(exWbValid),
		.inData(exWbOut),
		.outValid(wbValid),
		.outData(wbOut)
	);

	assign wbWriteEn = wbValid && wbOut.regWrite;
	assign retireValid = wbValid;
	assign retire.regWrite = wbOut.regWrite;
	assign retire.rd = wbOut.rd;
	assign retire.result = wbOut.result;

endmodule

`default_nettype wire

//--- tb/armPipeTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "armPipe_params.svh"

module armPipeTb;

	localparam int numInstr = 2000;
	localparam int cycleLimit = numInstr * 3 + 100;
	localparam int dataW = `ARMPIPE_DATA_WIDTH;

	logic Clk = 1'b0;
	logic rstN;
	logic instrValid;
	logic [dataW-1:0] instr;
	logic [dataW-1:0] pc;
	logic retireValid;
	armPipePkg::retireT retire;
	armPipePkg::flagsT flags;

	logic [31:0] rngState;
	logic [31:0] idleRoll;
	logic [dataW-1:0] pcNext;
	logic [dataW-1:0] modelRegs [0:14];
	armPipePkg::flagsT modelFlags;
	armPipePkg::flagsT lastFlags; // Flags after the newest retirement
	armPipePkg::retireT expRetireQ [$];
	armPipePkg::flagsT expFlagsQ [$];
	int dueCycleQ [$];
	int cycleCount = 0;
	int issued;

	armPipe UUT (
		.Clk(Clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.retireValid(retireValid),
		.retire(retire),
		.flags(flags)
	);

	always #50 Clk = ~Clk;

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			abortRun();
		end
	end

	task automatic abortRun();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic checkValid(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR retireValid got %h expected %h", got, exp);
			abortRun();
		end
	endtask

	task automatic checkRetire(input armPipePkg::retireT got, input armPipePkg::retireT exp);
		if (got.regWrite !== exp.regWrite || got.rd !== exp.rd ||
			(exp.regWrite && got.result !== exp.result)) begin
			$display("ERR retire got %h expected %h", got, exp);
			abortRun();
		end
	endtask

	task automatic checkFlags(input armPipePkg::flagsT got, input armPipePkg::flagsT exp);
		if (got !== exp) begin
			$display("ERR flags got %h expected %h", got, exp);
			abortRun();
		end
	endtask

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic logic [3:0] pickReg(input logic [7:0] r);
		if (r[1:0] != 2'b00) begin
			return {2'b00, r[3:2]}; // Mostly r0 to r3
		end
		return r[7:4];
	endfunction

	function automatic logic [31:0] makeInstr();
		logic [31:0] r1, r2;
		logic [3:0] cond, funct, rd;
		logic [1:0] cls;
		logic [7:0] low;
		r1 = xorshift();
		r2 = xorshift();
		cond = r1[0] ? 4'he : r1[4:1];
		if (cond == 4'hf) begin
			cond = 4'he;
		end
		case (r1[8:5])
			4'd0: funct = 4'b0000;
			4'd1: funct = 4'b0001;
			4'd2, 4'd10: funct = 4'b0010;
			4'd3: funct = 4'b0011;
			4'd4, 4'd9: funct = 4'b0100;
			4'd5: funct = 4'b1100;
			4'd6, 4'd12: funct = 4'b1101;
			4'd7: funct = 4'b1110;
			4'd8, 4'd11: funct = 4'b1010;
			4'd13: funct = 4'b0101; // ADC is unsupported
			4'd14: funct = 4'b1111; // MVN is unsupported
			default: funct = 4'b1000; // TST is unsupported
		endcase
		cls = (r1[12:9] == 4'd0) ? {r1[13], ~r1[13]} : 2'b00; // Rare load/store or branch class
		rd = pickReg(r2[23:16]);
		if (rd == 4'd15) begin
			rd = 4'd14;
		end
		low = r2[24] ? r1[31:24] : {4'h0, pickReg(r2[15:8])};
		return {cond, cls, r2[24], funct, r2[25], pickReg(r2[7:0]), rd, 4'h0, low};
	endfunction

	function automatic logic [dataW-1:0] readReg(input logic [3:0] r, input logic [dataW-1:0] pcNow);
		if (r == 4'd15) begin
			return pcNow + dataW'(8);
		end
		return modelRegs[r];
	endfunction

	function automatic logic condHolds(input logic [3:0] cond, input armPipePkg::flagsT f);
		logic base;
		case (cond[3:1])
			3'd0: base = f.z;
			3'd1: base = f.c;
			3'd2: base = f.n;
			3'd3: base = f.v;
			3'd4: base = f.c & ~f.z;
			3'd5: base = (f.n == f.v);
			3'd6: base = ~f.z & (f.n == f.v);
			default: base = 1'b1;
		endcase
		return base ^ cond[0]; // Odd codes test the inverse
	endfunction

	task automatic issueInstr(input logic [31:0] word);
		logic [3:0] funct, rd;
		logic [dataW-1:0] a, b, res;
		logic [dataW:0] wide;
		logic [dataW:0] sWide;
		logic known, isCmp, pass, writes, c, v;
		armPipePkg::retireT exp;
		funct = word[24:21];
		rd = word[15:12];
		a = readReg(word[19:16], pcNext);
		b = word[25] ? {{(dataW - 8){1'b0}}, word[7:0]} : readReg(word[3:0], pcNext);
		known = (word[27:26] == 2'b00);
		res = '0;
		c = modelFlags.c; // Logical operations keep c and v
		v = modelFlags.v;
		case (funct)
			4'b0000: res = a & b;
			4'b0001: res = a ^ b;
			4'b1100: res = a | b;
			4'b1101: res = b;
			4'b1110: res = a & ~b;
			4'b0100: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[dataW-1:0];
				c = wide[dataW];
				sWide = {a[dataW-1], a} + {b[dataW-1], b};
				v = (sWide[dataW] != sWide[dataW-1]); // Signed sum out of range
			end
			4'b0010, 4'b1010: begin
				res = a - b;
				c = (a >= b); // No borrow
				sWide = {a[dataW-1], a} - {b[dataW-1], b};
				v = (sWide[dataW] != sWide[dataW-1]);
			end
			4'b0011: begin
				res = b - a;
				c = (b >= a);
				sWide = {b[dataW-1], b} - {a[dataW-1], a};
				v = (sWide[dataW] != sWide[dataW-1]);
			end
			default: known = 1'b0;
		endcase
		isCmp = (funct == 4'b1010);
		pass = condHolds(word[31:28], modelFlags);
		writes = known && pass && !isCmp;
		if (known && pass && (word[20] || isCmp)) begin
			modelFlags.n = res[dataW-1];
			modelFlags.z = (res == '0);
			modelFlags.c = c;
			modelFlags.v = v;
		end
		if (writes && rd != 4'd15) begin
			modelRegs[rd] = res;
		end
		exp.regWrite = writes;
		exp.rd = rd;
		exp.result = res;
		expRetireQ.push_back(exp);
		expFlagsQ.push_back(modelFlags);
		dueCycleQ.push_back(cycleCount + 2); // Writeback stage two edges after sampling
		instrValid = 1'b1;
		instr = word;
		pc = pcNext;
		pcNext = pcNext + dataW'(4);
		issued++;
	endtask

	task automatic checkOutputs();
		logic expValid;
		expValid = 1'b0;
		if (dueCycleQ.size() > 0) begin
			expValid = (dueCycleQ[0] == cycleCount);
		end
		checkValid(retireValid, expValid);
		if (expValid) begin
			checkRetire(retire, expRetireQ[0]);
			checkFlags(flags, expFlagsQ[0]);
			lastFlags = expFlagsQ[0];
			void'(expRetireQ.pop_front());
			void'(expFlagsQ.pop_front());
			void'(dueCycleQ.pop_front());
		end else begin
			checkFlags(flags, lastFlags);
		end
	endtask

	initial begin
		rngState = 32'hd970ebe0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		issued = 0;
		modelFlags = '0;
		lastFlags = '0;
		for (int i = 0; i < 15; i++) begin
			modelRegs[i] = '0;
		end
		pcNext = xorshift() & 32'hffff_fffc;
		repeat (8) begin
			@(negedge Clk);
			checkValid(retireValid, 1'b0);
			checkFlags(flags, '0);
		end
		rstN = 1'b1;
		repeat (2) begin
			@(negedge Clk);
			checkOutputs();
		end
		while (issued < numInstr) begin
			@(negedge Clk);
			checkOutputs();
			idleRoll = xorshift();
			if (idleRoll[2:0] == 3'd0) begin
				instrValid = 1'b0;
				instr = idleRoll; // Garbage on an idle cycle
			end else begin
				issueInstr(makeInstr());
			end
		end
		while (dueCycleQ.size() > 0) begin
			@(negedge Clk);
			checkOutputs();
			instrValid = 1'b0;
		end
		repeat (2) begin
			@(negedge Clk);
			checkOutputs();
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- armPipe.f
+incdir+hw
hw/armPipePkg.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/decodeStage.sv
hw/pipeReg.sv
hw/executeStage.sv
hw/armPipe.sv
tb/armPipeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the armPipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f armPipe.f \
	--top-module armPipeTb -o armPipeSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOut=$(./obj_dir/armPipeSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
